/* tb/ex_trace.txt */
# name opclass(0 alu 1 mul 2 csr 3 load) op a b c tag_a tag_b tpcr flags
# then exp_data exp_tag exp_aux (branch decision or load write enable)
add_basic    0 0 00000005 00000007 00000000 1 0 01 00 0000000c 1 0
sub_wrap     0 1 00000003 00000005 00000000 0 1 02 00 fffffffe 0 0
and_mask     0 2 ff00ff00 0f0f0f0f 00000000 1 1 02 00 0f000f00 1 0
or_bits      0 3 12340000 00005678 00000000 1 0 03 00 12345678 1 0
xor_bits     0 4 aaaaaaaa ffffffff 00000000 1 1 00 00 55555555 0 0
sll_shift    0 5 00000001 0000001f 00000000 0 1 01 00 80000000 1 0
srl_shift    0 6 80000000 00000024 00000000 0 0 01 00 08000000 0 0
sra_shift    0 7 80000000 00000004 00000000 1 0 02 00 f8000000 0 0
beq_taken    0 8 00001234 00001234 00000400 0 0 00 01 00000001 0 1
bne_not      0 9 00000005 00000005 00000800 0 1 03 01 00000000 0 0
blt_signed   0 a ffffffff 00000001 00001000 0 1 01 01 00000001 1 1
bltu_not     0 b ffffffff 00000001 00002000 1 1 02 01 00000000 1 0
mul_lo_small 1 0 00000007 00000006 00000000 1 0 04 00 0000002a 1 0
mul_hu_big   1 1 ffffffff ffffffff 00000000 1 1 08 00 fffffffe 1 0
mul_lo_big   1 0 ffffffff ffffffff 00000000 0 1 0c 00 00000001 0 0
mul_hu_mid   1 1 12345678 00010000 00000000 1 1 00 00 00001234 0 0
mul_zero     1 0 deadbeef 00000000 00000000 1 1 04 00 00000000 1 0
mul_stall    1 0 00010001 00000003 00000000 0 1 04 50 00030003 1 0
mul_stall_hu 1 1 80000000 80000000 00000000 1 0 0c 30 40000000 1 0
csr_or       2 0 00000001 00000002 cafef00d 0 1 10 00 cafef00d 1 0
csr_and      2 0 00000010 00000020 00000fff 1 0 20 00 00000fff 0 0
load_ok      3 0 13572468 0000000a 00000000 1 0 40 01 13572468 1 1
load_err     3 0 11112222 0000000b 00000000 1 0 c0 03 11112222 1 0
load_nowe    3 0 33334444 0000000c 00000000 1 0 80 00 33334444 0 0
load_tag_a   3 0 55556666 0000003f 00000000 1 0 c0 01 55556666 1 1
load_clear   3 0 9abcdef0 00000001 00000000 1 0 00 01 9abcdef0 0 1

/* verilog.f */
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_tag_prop.sv
hdl/ex_wb_ctrl.sv
hdl/ex_stage.sv
tb/ex_stage_properties.sv
tb/tb_ex_stage.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_stage -f verilog.f \
  && ./obj_dir/Vtb_ex_stage | tee /dev/stderr | grep -q "All checks passed" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* tb/tb_ex_stage.sv */
// Execute stage testbench with clock, reset, trace-driven stimulus, checks and report
`timescale 1ns/1ps

module tb_ex_stage;

  // Bound on every handshake wait in cycles
  localparam int TIMEOUT_CYCLES = 100;

  logic                          clk;
  logic                          rst_n;
  logic                          alu_en_i;
  ex_pkg::alu_op_e               alu_operator_i;
  logic [ex_pkg::XLEN-1:0]       alu_operand_a_i;
  logic [ex_pkg::XLEN-1:0]       alu_operand_b_i;
  logic [ex_pkg::XLEN-1:0]       alu_operand_c_i;
  logic                          mult_en_i;
  ex_pkg::mult_op_e              mult_operator_i;
  logic [ex_pkg::XLEN-1:0]       mult_operand_a_i;
  logic [ex_pkg::XLEN-1:0]       mult_operand_b_i;
  logic                          csr_access_i;
  logic [ex_pkg::XLEN-1:0]       csr_rdata_i;
  ex_pkg::opclass_e              opclass_i;
  logic                          operand_a_tag_i;
  logic                          operand_b_tag_i;
  logic [ex_pkg::TPCR_W-1:0]     tpcr_i;
  logic                          regfile_alu_we_i;
  logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_i;
  logic                          regfile_we_i;
  logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_i;
  logic                          lsu_en_i;
  logic                          lsu_ready_ex_i;
  logic                          lsu_err_i;
  logic [ex_pkg::XLEN-1:0]       lsu_rdata_i;
  logic                          lsu_rtag_i;
  logic                          branch_in_ex_i;
  logic                          wb_ready_i;
  logic                          regfile_alu_we_fw_o;
  logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_fw_o;
  logic [ex_pkg::XLEN-1:0]       regfile_alu_wdata_fw_o;
  logic                          regfile_alu_wtag_fw_o;
  logic                          regfile_we_wb_o;
  logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_wb_o;
  logic [ex_pkg::XLEN-1:0]       regfile_wdata_wb_o;
  logic                          regfile_wtag_wb_o;
  logic [ex_pkg::XLEN-1:0]       jump_target_o;
  logic                          branch_decision_o;
  logic                          ex_ready_o;
  logic                          ex_valid_o;

  // Run bookkeeping
  int              errors;
  int              test_errors;
  int              tests_run;
  int              tests_failed;
  bit              aborted;
  logic [8*24-1:0] test_name;

  // Current trace row in hex except the name
  logic [31:0] f_opc, f_op, f_a, f_b, f_c, f_ta, f_tb, f_tpcr, f_flags;
  logic [31:0] exp_data, exp_tag, exp_aux;

  ex_stage i_dut (.*);

  bind ex_stage ex_stage_properties i_props (
    .clk             (clk),
    .rst_n           (rst_n),
    .wb_ready_i      (wb_ready_i),
    .branch_in_ex_i  (branch_in_ex_i),
    .ex_ready_i      (ex_ready_o),
    .ex_valid_i      (ex_valid_o),
    .regfile_we_wb_i (regfile_we_wb_o)
  );

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error: test %0s, %0s: expected %h, actual %h", test_name, what,
               expected, actual);
      test_errors++;
    end
  endtask

  // No operation in EX and WB accepting
  task automatic drive_idle();
    alu_en_i         = 1'b0;
    mult_en_i        = 1'b0;
    csr_access_i     = 1'b0;
    lsu_en_i         = 1'b0;
    regfile_alu_we_i = 1'b0;
    regfile_we_i     = 1'b0;
    lsu_err_i        = 1'b0;
    branch_in_ex_i   = 1'b0;
    wb_ready_i       = 1'b1;
  endtask

  task automatic init_inputs();
    drive_idle();
    rst_n               = 1'b0;
    alu_operator_i      = ex_pkg::ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    mult_operator_i     = ex_pkg::MUL_LO;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    csr_rdata_i         = '0;
    opclass_i           = ex_pkg::OPC_ALU;
    operand_a_tag_i     = 1'b0;
    operand_b_tag_i     = 1'b0;
    tpcr_i              = '0;
    regfile_alu_waddr_i = '0;
    regfile_waddr_i     = '0;
    lsu_ready_ex_i      = 1'b1;
    lsu_rdata_i         = '0;
    lsu_rtag_i          = 1'b0;
  endtask

  // Row opclass picks which unit is driven
  task automatic drive_row();
    opclass_i           = ex_pkg::opclass_e'(f_opc[1:0]);
    operand_a_tag_i     = f_ta[0];
    operand_b_tag_i     = f_tb[0];
    tpcr_i              = f_tpcr[7:0];
    // Upper flag nibble is the back-pressure length
    wb_ready_i          = (f_flags[7:4] == 4'd0);
    regfile_alu_waddr_i = tests_run[5:0];
    case (f_opc[1:0])
      ex_pkg::OPC_ALU: begin
        alu_en_i         = 1'b1;
        alu_operator_i   = ex_pkg::alu_op_e'(f_op[3:0]);
        alu_operand_a_i  = f_a;
        alu_operand_b_i  = f_b;
        alu_operand_c_i  = f_c;
        // Branches do not write the register file
        branch_in_ex_i   = f_flags[0];
        regfile_alu_we_i = ~f_flags[0];
      end
      ex_pkg::OPC_MULT: begin
        mult_en_i        = 1'b1;
        mult_operator_i  = ex_pkg::mult_op_e'(f_op[0]);
        mult_operand_a_i = f_a;
        mult_operand_b_i = f_b;
        regfile_alu_we_i = 1'b1;
      end
      ex_pkg::OPC_CSR: begin
        // ALU busy too so CSR data must win
        csr_access_i     = 1'b1;
        alu_en_i         = 1'b1;
        alu_operator_i   = ex_pkg::alu_op_e'(f_op[3:0]);
        alu_operand_a_i  = f_a;
        alu_operand_b_i  = f_b;
        alu_operand_c_i  = f_c;
        csr_rdata_i      = f_c;
        regfile_alu_we_i = 1'b1;
      end
      default: begin
        lsu_en_i        = 1'b1;
        regfile_we_i    = f_flags[0];
        lsu_err_i       = f_flags[1];
        lsu_rdata_i     = f_a;
        lsu_rtag_i      = f_ta[0];
        regfile_waddr_i = f_b[5:0];
      end
    endcase
  endtask

  task automatic wait_ready(output bit ok);
    int cycles;
    cycles = 0;
    ok = 1'b0;
    while (!ok && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      if (ex_ready_o === 1'b1) begin
        ok = 1'b1;
      end else begin
        cycles++;
      end
    end
    if (!ok) begin
      $display("Timeout: the execute stage gave no ready within %0d cycles in test %0s",
               TIMEOUT_CYCLES, test_name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Per-row checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_outputs();
    logic [31:0] exp_we;
    exp_we = ((f_opc[1:0] == ex_pkg::OPC_ALU) && f_flags[0]) ? 32'd0 : 32'd1;
    check_value("ex_valid", 32'd1, 32'(ex_valid_o));
    if (f_opc[1:0] != ex_pkg::OPC_LOAD) begin
      check_value("forward data", exp_data, regfile_alu_wdata_fw_o);
      check_value("forward tag", exp_tag, 32'(regfile_alu_wtag_fw_o));
      check_value("forward enable", exp_we, 32'(regfile_alu_we_fw_o));
      check_value("forward address", 32'(tests_run[5:0]), 32'(regfile_alu_waddr_fw_o));
    end
    if (f_opc[1:0] == ex_pkg::OPC_ALU) begin
      check_value("branch decision", exp_aux, 32'(branch_decision_o));
      check_value("jump target", f_c, jump_target_o);
    end
  endtask

  task automatic run_row();
    bit ok;
    int i;
    test_errors = 0;
    @(posedge clk);
    #1;
    drive_row();
    if (f_opc[1:0] == ex_pkg::OPC_MULT) begin
      @(negedge clk);
      check_value("ready in first multiply cycle", 32'd0, 32'(ex_ready_o));
    end
    // WB stalled for the given number of cycles
    for (i = 0; i < int'(f_flags[7:4]); i++) begin
      @(negedge clk);
      check_value("ready under back-pressure", 32'd0, 32'(ex_ready_o));
      check_value("valid under back-pressure", 32'd0, 32'(ex_valid_o));
    end
    if (f_flags[7:4] != 4'd0) begin
      @(posedge clk);
      #1;
      wb_ready_i = 1'b1;
    end
    wait_ready(ok);
    if (!ok) begin
      aborted = 1'b1;
      test_errors++;
      return;
    end
    check_outputs();
    // Edge that consumes the operation
    @(posedge clk);
    #1;
    drive_idle();
    if (f_opc[1:0] == ex_pkg::OPC_LOAD) begin
      @(negedge clk);
      check_value("load write enable", exp_aux, 32'(regfile_we_wb_o));
      if (exp_aux[0]) begin
        check_value("load address", 32'(f_b[5:0]), 32'(regfile_waddr_wb_o));
        check_value("load data", exp_data, regfile_wdata_wb_o);
      end
      check_value("load tag", exp_tag, 32'(regfile_wtag_wb_o));
    end
  endtask

  task automatic report_test();
    tests_run++;
    errors += test_errors;
    if (test_errors == 0) begin
      $display("Test %0s: ok", test_name);
    end else begin
      tests_failed++;
      $display("Test %0s: %0d mismatches", test_name, test_errors);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int    fd;
    int    fields;
    string line;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    aborted      = 1'b0;
    init_inputs();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    test_name   = "reset";
    test_errors = 0;
    check_value("load write enable after reset", 32'd0, 32'(regfile_we_wb_o));
    check_value("ready after reset", 32'd1, 32'(ex_ready_o));
    report_test();
    fd = $fopen("tb/ex_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file tb/ex_trace.txt");
      aborted = 1'b1;
    end else begin
      while (!aborted && !$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0) begin
          fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h", test_name,
                           f_opc, f_op, f_a, f_b, f_c, f_ta, f_tb, f_tpcr, f_flags,
                           exp_data, exp_tag, exp_aux);
          // Comment and blank lines never give a full row
          if (fields == 13) begin
            run_row();
            report_test();
          end
        end
      end
      $fclose(fd);
    end
    $display("Tests run: %0d, tests with errors: %0d, mismatches: %0d", tests_run,
             tests_failed, errors);
    if (!aborted && errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* tb/ex_stage_properties.sv */
// Bound assertions on the execute stage handshake and the load-port reset state
`timescale 1ns/1ps

module ex_stage_properties (
  input logic clk,
  input logic rst_n,
  input logic wb_ready_i,
  input logic branch_in_ex_i,
  input logic ex_ready_i,
  input logic ex_valid_i,
  input logic regfile_we_wb_i
);

  // Load port empty on the edge after reset
  a_reset_we: assert property (@(posedge clk) !rst_n |=> !regfile_we_wb_i)
    else $error("load-port write enable set after reset");

  // Nothing leaves EX while WB is full
  a_valid_wb: assert property (@(posedge clk) disable iff (!rst_n)
                               ex_valid_i |-> wb_ready_i)
    else $error("ex_valid high while wb_ready low");

  // Back-pressure stalls ID unless a branch resolves
  a_stall: assert property (@(posedge clk) disable iff (!rst_n)
                            (!wb_ready_i && !branch_in_ex_i) |-> !ex_ready_i)
    else $error("ex_ready high while wb_ready low and no branch");

endmodule

/* hdl/ex_stage.sv */
// Execute stage top: ALU, multiplier, tag propagation and writeback control
`timescale 1ns/1ps

module ex_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  // ALU
  input  logic                          alu_en_i,
  input  ex_pkg::alu_op_e               alu_operator_i,
  input  logic [ex_pkg::XLEN-1:0]       alu_operand_a_i,
  input  logic [ex_pkg::XLEN-1:0]       alu_operand_b_i,
  input  logic [ex_pkg::XLEN-1:0]       alu_operand_c_i,
  // Multiplier
  input  logic                          mult_en_i,
  input  ex_pkg::mult_op_e              mult_operator_i,
  input  logic [ex_pkg::XLEN-1:0]       mult_operand_a_i,
  input  logic [ex_pkg::XLEN-1:0]       mult_operand_b_i,
  // CSR read data
  input  logic                          csr_access_i,
  input  logic [ex_pkg::XLEN-1:0]       csr_rdata_i,
  // Tags
  input  ex_pkg::opclass_e              opclass_i,
  input  logic                          operand_a_tag_i,
  input  logic                          operand_b_tag_i,
  input  logic [ex_pkg::TPCR_W-1:0]     tpcr_i,
  // Register file targets
  input  logic                          regfile_alu_we_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                          regfile_we_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_i,
  // LSU
  input  logic                          lsu_en_i,
  input  logic                          lsu_ready_ex_i,
  input  logic                          lsu_err_i,
  input  logic [ex_pkg::XLEN-1:0]       lsu_rdata_i,
  input  logic                          lsu_rtag_i,
  input  logic                          branch_in_ex_i,
  input  logic                          wb_ready_i,
  // Forwarding port
  output logic                          regfile_alu_we_fw_o,
  output logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [ex_pkg::XLEN-1:0]       regfile_alu_wdata_fw_o,
  output logic                          regfile_alu_wtag_fw_o,
  // Load port
  output logic                          regfile_we_wb_o,
  output logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [ex_pkg::XLEN-1:0]       regfile_wdata_wb_o,
  output logic                          regfile_wtag_wb_o,
  // To IF
  output logic [ex_pkg::XLEN-1:0]       jump_target_o,
  output logic                          branch_decision_o,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o
);

  logic [ex_pkg::XLEN-1:0] alu_result;
  logic [ex_pkg::XLEN-1:0] mult_result;
  logic                    mult_ready;
  logic                    alu_tag;
  logic                    lsu_tag;

  // Jump target computed in ID
  assign jump_target_o = alu_operand_c_i;

  ex_alu i_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  // Stage ready releases a finished product
  ex_mult i_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable_i   (mult_en_i),
    .operator_i (mult_operator_i),
    .op_a_i     (mult_operand_a_i),
    .op_b_i     (mult_operand_b_i),
    .ex_ready_i (ex_ready_o),
    .result_o   (mult_result),
    .ready_o    (mult_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Tag units
  ////////////////////////////////////////////////////////////////////////////

  ex_tag_prop i_tag_alu (
    .opclass_i (opclass_i),
    .tag_a_i   (operand_a_tag_i),
    .tag_b_i   (operand_b_tag_i),
    .tpcr_i    (tpcr_i),
    .tag_o     (alu_tag)
  );

  // Load data has a single source tag
  ex_tag_prop i_tag_lsu (
    .opclass_i (ex_pkg::OPC_LOAD),
    .tag_a_i   (lsu_rtag_i),
    .tag_b_i   (1'b0),
    .tpcr_i    (tpcr_i),
    .tag_o     (lsu_tag)
  );

  ex_wb_ctrl i_wb_ctrl (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .alu_tag_i              (alu_tag),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .lsu_tag_i              (lsu_tag),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .mult_ready_i           (mult_ready),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_alu_wtag_fw_o  (regfile_alu_wtag_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .regfile_wtag_wb_o      (regfile_wtag_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

/* hdl/ex_wb_ctrl.sv */
// Write-port muxes, EX/WB pipeline register and EX stage ready/valid logic
`timescale 1ns/1ps

module ex_wb_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          alu_en_i,
  input  logic                          mult_en_i,
  input  logic                          csr_access_i,
  input  logic                          lsu_en_i,
  input  logic [ex_pkg::XLEN-1:0]       alu_result_i,
  input  logic [ex_pkg::XLEN-1:0]       mult_result_i,
  input  logic [ex_pkg::XLEN-1:0]       csr_rdata_i,
  input  logic                          alu_tag_i,
  input  logic                          regfile_alu_we_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                          regfile_we_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic [ex_pkg::XLEN-1:0]       lsu_rdata_i,
  input  logic                          lsu_tag_i,
  input  logic                          lsu_ready_ex_i,
  input  logic                          lsu_err_i,
  input  logic                          mult_ready_i,
  input  logic                          wb_ready_i,
  input  logic                          branch_in_ex_i,
  output logic                          regfile_alu_we_fw_o,
  output logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [ex_pkg::XLEN-1:0]       regfile_alu_wdata_fw_o,
  output logic                          regfile_alu_wtag_fw_o,
  output logic                          regfile_we_wb_o,
  output logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [ex_pkg::XLEN-1:0]       regfile_wdata_wb_o,
  output logic                          regfile_wtag_wb_o,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o
);

  // EX/WB register
  logic                          we_lsu_q;
  logic [ex_pkg::REG_ADDR_W-1:0] waddr_lsu_q;
  logic                          we_lsu_nxt;
  // All units able to finish this cycle
  logic                          units_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
  assign regfile_alu_wtag_fw_o  = alu_tag_i;

  // CSR wins over mult, mult over ALU
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Load port and EX/WB register
  ////////////////////////////////////////////////////////////////////////////

  // Faulting loads never write
  assign we_lsu_nxt = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_lsu_q <= 1'b0;
    end else if (ex_valid_o) begin
      we_lsu_q <= we_lsu_nxt;
    end else if (wb_ready_i) begin
      // Bubble into WB
      we_lsu_q <= 1'b0;
    end
  end

  // Address kept only for real writes
  always_ff @(posedge clk) begin
    if (ex_valid_o & we_lsu_nxt) begin
      waddr_lsu_q <= regfile_waddr_i;
    end
  end

  assign regfile_we_wb_o    = we_lsu_q;
  assign regfile_waddr_wb_o = waddr_lsu_q;
  assign regfile_wdata_wb_o = lsu_rdata_i;
  assign regfile_wtag_wb_o  = lsu_tag_i;

  ////////////////////////////////////////////////////////////////////////////
  // Stage handshake
  ////////////////////////////////////////////////////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  // Branches complete without WB
  assign ex_ready_o  = units_ready | branch_in_ex_i;
  assign ex_valid_o  = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

/* hdl/ex_tag_prop.sv */
// Taint tag propagation: per-class mode from the TPCR applied to two operand tags
`timescale 1ns/1ps

module ex_tag_prop (
  input  ex_pkg::opclass_e          opclass_i,
  input  logic                      tag_a_i,
  input  logic                      tag_b_i,
  input  logic [ex_pkg::TPCR_W-1:0] tpcr_i,
  output logic                      tag_o
);

  // Field for this op class
  logic [ex_pkg::PROP_W-1:0] mode_bits;
  ex_pkg::prop_mode_e        mode;

  ////////////////////////////////////////////////////////////////////////////
  // Mode select
  ////////////////////////////////////////////////////////////////////////////

  // Field i sits at bits [2i+1:2i]
  assign mode_bits = tpcr_i[int'(opclass_i)*ex_pkg::PROP_W +: ex_pkg::PROP_W];
  assign mode      = ex_pkg::prop_mode_e'(mode_bits);

  ////////////////////////////////////////////////////////////////////////////
  // Tag combine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (mode)
      // Result never tainted
      ex_pkg::PROP_CLEAR: tag_o = 1'b0;
      // Tainted if either source is
      ex_pkg::PROP_OR:    tag_o = tag_a_i | tag_b_i;
      // Both sources must be tainted
      ex_pkg::PROP_AND:   tag_o = tag_a_i & tag_b_i;
      // Follows operand a only
      ex_pkg::PROP_A:     tag_o = tag_a_i;
      default:            tag_o = 1'b0;
    endcase
  end

endmodule

/* hdl/ex_mult.sv */
// Iterative shift-add multiplier, unsigned, variable latency with ready output
`timescale 1ns/1ps

module ex_mult (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    enable_i,
  input  ex_pkg::mult_op_e        operator_i,
  input  logic [ex_pkg::XLEN-1:0] op_a_i,
  input  logic [ex_pkg::XLEN-1:0] op_b_i,
  input  logic                    ex_ready_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    ready_o
);

  // Control state
  logic busy_q;
  logic done_q;
  logic start;
  logic last_step;

  // Datapath registers
  logic [2*ex_pkg::XLEN-1:0]   acc_q, mcand_q;
  logic [ex_pkg::XLEN-1:0]     mplier_q;
  logic [ex_pkg::MULT_CNT_W-1:0] cnt_q;

  // Step inputs and outputs
  logic [2*ex_pkg::XLEN-1:0]   step_acc, step_mcand;
  logic [ex_pkg::XLEN-1:0]     step_mplier;
  logic [ex_pkg::MULT_CNT_W-1:0] step_cnt;
  logic [2*ex_pkg::XLEN-1:0]   acc_nxt, mcand_nxt;
  logic [ex_pkg::XLEN-1:0]     mplier_nxt;
  logic [ex_pkg::MULT_CNT_W-1:0] cnt_nxt;

  // New op only from idle
  assign start   = enable_i & ~busy_q & ~done_q;
  // Drops in the start cycle already
  assign ready_o = ~(start | busy_q);

  // First step runs straight from the operands
  assign step_acc    = start ? '0 : acc_q;
  assign step_mcand  = start ? {{ex_pkg::XLEN{1'b0}}, op_a_i} : mcand_q;
  assign step_mplier = start ? op_b_i : mplier_q;
  assign step_cnt    = start ? '0 : cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // One shift-add step
  ////////////////////////////////////////////////////////////////////////////

  assign acc_nxt    = step_mplier[0] ? step_acc + step_mcand : step_acc;
  assign mcand_nxt  = step_mcand << 1;
  assign mplier_nxt = step_mplier >> 1;
  assign cnt_nxt    = step_cnt + 1'b1;
  // Stop when no set bits are left
  assign last_step  = (mplier_nxt == '0) | (cnt_nxt == ex_pkg::MULT_MAX_STEPS);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else if (start | busy_q) begin
      busy_q <= ~last_step;
      done_q <= last_step;
    end else if (done_q & ex_ready_i) begin
      // Result consumed, back to idle
      done_q <= 1'b0;
    end
  end

  // Payload, advances only while running
  always_ff @(posedge clk) begin
    if (start | busy_q) begin
      acc_q    <= acc_nxt;
      mcand_q  <= mcand_nxt;
      mplier_q <= mplier_nxt;
      cnt_q    <= cnt_nxt;
    end
  end

  // Word select
  assign result_o = (operator_i == ex_pkg::MUL_HU) ? acc_q[2*ex_pkg::XLEN-1:ex_pkg::XLEN]
                                                   : acc_q[ex_pkg::XLEN-1:0];

endmodule

/* hdl/ex_alu.sv */
// Single-cycle ALU: add, sub, logic, shifts and compares with branch result
`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::alu_op_e             operator_i,
  input  logic [ex_pkg::XLEN-1:0]     operand_a_i,
  input  logic [ex_pkg::XLEN-1:0]     operand_b_i,
  output logic [ex_pkg::XLEN-1:0]     result_o,
  output logic                        cmp_result_o
);

  // Shift amount from the low bits of b
  logic [4:0]              shamt;
  logic [ex_pkg::XLEN-1:0] sra_result;
  logic                    lt_signed;
  logic                    lt_unsigned;

  assign shamt       = operand_b_i[4:0];
  // Arithmetic shift keeps the sign of a
  assign sra_result  = $unsigned($signed(operand_a_i) >>> shamt);
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;

  ////////////////////////////////////////////////////////////////////////////
  // Compare decision
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      ex_pkg::ALU_EQ:  cmp_result_o = (operand_a_i == operand_b_i);
      ex_pkg::ALU_NE:  cmp_result_o = (operand_a_i != operand_b_i);
      ex_pkg::ALU_LTS: cmp_result_o = lt_signed;
      ex_pkg::ALU_LTU: cmp_result_o = lt_unsigned;
      // No branch taken on arithmetic ops
      default:         cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      ex_pkg::ALU_ADD: result_o = operand_a_i + operand_b_i;
      ex_pkg::ALU_SUB: result_o = operand_a_i - operand_b_i;
      ex_pkg::ALU_AND: result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:  result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL: result_o = operand_a_i << shamt;
      ex_pkg::ALU_SRL: result_o = operand_a_i >> shamt;
      ex_pkg::ALU_SRA: result_o = sra_result;
      // Compares give 0 or 1 in bit 0
      ex_pkg::ALU_EQ,
      ex_pkg::ALU_NE,
      ex_pkg::ALU_LTS,
      ex_pkg::ALU_LTU: result_o = {{(ex_pkg::XLEN-1){1'b0}}, cmp_result_o};
      default:         result_o = '0;
    endcase
  end

endmodule

/* hdl/ex_pkg.sv */
// Execute stage package: widths, ALU and multiplier operators, op classes, tag modes
package ex_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Data path
  localparam int unsigned XLEN       = 32;
  // Register file address, 64 entries
  localparam int unsigned REG_ADDR_W = 6;
  // One tag mode field
  localparam int unsigned PROP_W     = 2;
  // One PROP_W field per operation class
  localparam int unsigned TPCR_W     = 8;
  // Multiplier step counter, must hold XLEN
  localparam int unsigned MULT_CNT_W = 6;

  // Bound on shift-add steps
  localparam logic [MULT_CNT_W-1:0] MULT_MAX_STEPS = MULT_CNT_W'(XLEN);

  ////////////////////////////////////////////////////////////////////////////
  // Operator codes
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLL = 4'd5,
    ALU_SRL = 4'd6,
    ALU_SRA = 4'd7,
    // Compares, also the branch decision
    ALU_EQ  = 4'd8,
    ALU_NE  = 4'd9,
    ALU_LTS = 4'd10,
    ALU_LTU = 4'd11
  } alu_op_e;

  // Low or high word of the unsigned product
  typedef enum logic {
    MUL_LO = 1'b0,
    MUL_HU = 1'b1
  } mult_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Tag propagation
  ////////////////////////////////////////////////////////////////////////////

  // Index into the TPCR fields
  typedef enum logic [1:0] {
    OPC_ALU  = 2'd0,
    OPC_MULT = 2'd1,
    OPC_CSR  = 2'd2,
    OPC_LOAD = 2'd3
  } opclass_e;

  typedef enum logic [PROP_W-1:0] {
    PROP_CLEAR = 2'd0,
    PROP_OR    = 2'd1,
    PROP_AND   = 2'd2,
    PROP_A     = 2'd3
  } prop_mode_e;

endpackage
